// File: hdl/fetch_pkg.sv
// --------------------------------------------------------------------------
// fetch front end constants
// sizes of the predictors and the queue, and the control-flow kinds
// --------------------------------------------------------------------------
package fetch_pkg;

    // address and instruction widths
    localparam int unsigned VLEN = 32;
    localparam int unsigned ILEN = 32;

    // branch history table, indexed by pc bits above the word offset
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = $clog2(BHT_ENTRIES);

    // return address stack
    localparam int unsigned RAS_DEPTH = 4;

    // fetch queue, count has to hold the value QUEUE_DEPTH itself
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // control-flow kind carried with every fetch entry
    typedef enum logic [2:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_JUMP_REG,
        CF_RETURN
    } cf_e;

endpackage

// File: hdl/rv_instr_pkg.sv
// --------------------------------------------------------------------------
// rv32i encodings
// opcodes, link registers and the instruction word seen in three formats
// --------------------------------------------------------------------------
package rv_instr_pkg;

    // control-flow opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;

    // x1 and x5 are the link registers of the calling convention
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // one instruction word, overlaid with the formats the scanner needs
    typedef union packed {
        // b-type, conditional branches
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        // j-type, jal
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        // i-type, jalr and the register fields used for call/return
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

// File: hdl/instr_scan.sv
// --------------------------------------------------------------------------
// instruction scanner
// classifies one word as branch, jal or jalr and extracts its offset
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module instr_scan (
    input  rv_instr_pkg::instr_u        instr_i,
    output logic                        is_branch_o,
    output logic                        is_jal_o,
    output logic                        is_jalr_o,
    output logic                        is_call_o,
    output logic                        is_return_o,
    output logic [fetch_pkg::VLEN-1:0]  imm_o
);
    logic                       rd_link;
    logic                       rs1_link;
    logic [fetch_pkg::VLEN-1:0] b_imm;
    logic [fetch_pkg::VLEN-1:0] j_imm;

    // opcode sits in the same bits for every format
    assign is_branch_o = instr_i.i.opcode == rv_instr_pkg::OPC_BRANCH;
    assign is_jal_o    = instr_i.i.opcode == rv_instr_pkg::OPC_JAL;
    assign is_jalr_o   = instr_i.i.opcode == rv_instr_pkg::OPC_JALR;

    // ra or t0 as link register
    assign rd_link  = (instr_i.i.rd == rv_instr_pkg::REG_RA) ||
                      (instr_i.i.rd == rv_instr_pkg::REG_T0);
    assign rs1_link = (instr_i.i.rs1 == rv_instr_pkg::REG_RA) ||
                      (instr_i.i.rs1 == rv_instr_pkg::REG_T0);

    // call writes a link register, return reads one and discards the link
    assign is_call_o   = (is_jal_o || is_jalr_o) && rd_link;
    assign is_return_o = is_jalr_o && rs1_link && (instr_i.i.rd == 5'd0);

    // sign-extended offsets, bit 0 always zero
    assign b_imm = {{(fetch_pkg::VLEN - 12){instr_i.b.imm12}}, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign j_imm = {{(fetch_pkg::VLEN - 20){instr_i.j.imm20}}, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

    // jal offset unless it is a branch
    assign imm_o = is_branch_o ? b_imm : j_imm;

endmodule

// File: hdl/bht.sv
// --------------------------------------------------------------------------
// branch history table
// two-bit saturating counters with valid bits, trained by resolved branches
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module bht (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic [fetch_pkg::VLEN-1:0] pc_i,
    output logic                       valid_o,
    output logic                       taken_o,
    input  logic                       update_i,
    input  logic [fetch_pkg::VLEN-1:0] update_pc_i,
    input  logic                       update_taken_i
);
    logic [fetch_pkg::BHT_ENTRIES-1:0] valid_q;
    logic [1:0]                        cnt_q [fetch_pkg::BHT_ENTRIES];
    logic [fetch_pkg::BHT_IDX_W-1:0]   rd_idx;
    logic [fetch_pkg::BHT_IDX_W-1:0]   up_idx;

    // word-aligned index, bits 1:0 are always zero
    assign rd_idx = pc_i[fetch_pkg::BHT_IDX_W+1:2];
    assign up_idx = update_pc_i[fetch_pkg::BHT_IDX_W+1:2];

    // counter msb is the prediction
    assign valid_o = valid_q[rd_idx];
    assign taken_o = cnt_q[rd_idx][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i) begin
            if (!valid_q[up_idx]) begin
                // first sighting starts weakly in the resolved direction
                cnt_q[up_idx] <= update_taken_i ? 2'b10 : 2'b01;
            end else if (update_taken_i && cnt_q[up_idx] != 2'b11) begin
                cnt_q[up_idx] <= cnt_q[up_idx] + 2'b01;
            end else if (!update_taken_i && cnt_q[up_idx] != 2'b00) begin
                cnt_q[up_idx] <= cnt_q[up_idx] - 2'b01;
            end
        end
    end

endmodule

// File: hdl/ras.sv
// --------------------------------------------------------------------------
// return address stack
// entry 0 is the top, the deepest entry falls off on push
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module ras (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic                       pop_i,
    input  logic [fetch_pkg::VLEN-1:0] push_addr_i,
    output logic                       top_valid_o,
    output logic [fetch_pkg::VLEN-1:0] top_addr_o
);
    localparam int unsigned D = fetch_pkg::RAS_DEPTH;

    logic [fetch_pkg::VLEN-1:0] addr_q [D];
    logic [D-1:0]               valid_q;

    assign top_valid_o = valid_q[0];
    assign top_addr_o  = addr_q[0];

    // valid bits shift along with the addresses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (push_i) begin
            valid_q <= {valid_q[D-2:0], 1'b1};
        end else if (pop_i) begin
            valid_q <= {1'b0, valid_q[D-1:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            addr_q[0] <= push_addr_i;
            for (int i = 1; i < D; i++) begin
                addr_q[i] <= addr_q[i-1];
            end
        end else if (pop_i) begin
            // bottom address stays, its valid bit is cleared
            for (int i = 0; i < D - 1; i++) begin
                addr_q[i] <= addr_q[i+1];
            end
        end
    end

endmodule

// File: hdl/fetch_queue.sv
// --------------------------------------------------------------------------
// fetch queue
// circular buffer of fetch entries towards the back end, with occupancy
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fetch_queue (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              wr_i,
    input  logic [fetch_pkg::VLEN-1:0]        wr_pc_i,
    input  logic [fetch_pkg::ILEN-1:0]        wr_instr_i,
    input  fetch_pkg::cf_e                    wr_cf_i,
    input  logic                              wr_taken_i,
    input  logic [fetch_pkg::VLEN-1:0]        wr_target_i,
    input  logic                              wr_ex_i,
    output logic [fetch_pkg::QUEUE_CNT_W-1:0] count_o,
    output logic                              fetch_valid_o,
    input  logic                              fetch_ready_i,
    output logic [fetch_pkg::VLEN-1:0]        fetch_pc_o,
    output logic [fetch_pkg::ILEN-1:0]        fetch_instr_o,
    output fetch_pkg::cf_e                    fetch_cf_o,
    output logic                              fetch_taken_o,
    output logic [fetch_pkg::VLEN-1:0]        fetch_target_o,
    output logic                              fetch_ex_o
);
    localparam int unsigned N = fetch_pkg::QUEUE_DEPTH;

    // entry storage, one array per field
    logic [fetch_pkg::VLEN-1:0]        pc_q     [N];
    logic [fetch_pkg::ILEN-1:0]        instr_q  [N];
    fetch_pkg::cf_e                    cf_q     [N];
    logic [N-1:0]                      taken_q;
    logic [fetch_pkg::VLEN-1:0]        target_q [N];
    logic [N-1:0]                      ex_q;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [fetch_pkg::QUEUE_CNT_W-1:0] count_q;
    logic                              push;
    logic                              pop;

    // pc_gen keeps room, the full check only guards the pointers
    assign push = wr_i && (count_q != N[fetch_pkg::QUEUE_CNT_W-1:0]);
    assign pop  = fetch_valid_o && fetch_ready_i;

    assign count_o       = count_q;
    assign fetch_valid_o = count_q != '0;

    // head entry read combinationally
    assign fetch_pc_o     = pc_q[rd_ptr_q];
    assign fetch_instr_o  = instr_q[rd_ptr_q];
    assign fetch_cf_o     = cf_q[rd_ptr_q];
    assign fetch_taken_o  = taken_q[rd_ptr_q];
    assign fetch_target_o = target_q[rd_ptr_q];
    assign fetch_ex_o     = ex_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_q[wr_ptr_q]     <= wr_pc_i;
            instr_q[wr_ptr_q]  <= wr_instr_i;
            cf_q[wr_ptr_q]     <= wr_cf_i;
            taken_q[wr_ptr_q]  <= wr_taken_i;
            target_q[wr_ptr_q] <= wr_target_i;
            ex_q[wr_ptr_q]     <= wr_ex_i;
        end
    end

endmodule

// File: hdl/pc_gen.sv
// --------------------------------------------------------------------------
// pc generation
// next-pc selection, memory request issue and discard of stale responses
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module pc_gen (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [fetch_pkg::VLEN-1:0]        boot_addr_i,
    input  logic                              mispredict_i,
    input  logic [fetch_pkg::VLEN-1:0]        mispredict_target_i,
    input  logic                              commit_flush_i,
    input  logic [fetch_pkg::VLEN-1:0]        commit_pc_i,
    input  logic                              ex_valid_i,
    input  logic [fetch_pkg::VLEN-1:0]        trap_vector_i,
    input  logic                              eret_i,
    input  logic [fetch_pkg::VLEN-1:0]        epc_i,
    input  logic                              rsp_i,
    input  logic                              predict_i,
    input  logic [fetch_pkg::VLEN-1:0]        predict_addr_i,
    input  logic [fetch_pkg::QUEUE_CNT_W-1:0] queue_count_i,
    output logic                              imem_req_o,
    output logic [fetch_pkg::VLEN-1:0]        imem_addr_o,
    output logic                              rsp_accept_o,
    output logic                              redirect_o
);
    logic [fetch_pkg::VLEN-1:0]      npc_q, npc_d;
    logic                            rst_load_q;
    logic                            outstanding_q;
    logic                            discard_q;
    logic [fetch_pkg::QUEUE_CNT_W:0] in_use;

    assign redirect_o = commit_flush_i || ex_valid_i || eret_i || mispredict_i;

    // a response in the redirect cycle belongs to the old path
    assign rsp_accept_o = rsp_i && !discard_q && !redirect_o;

    // queued entries plus the one in flight must leave room
    assign in_use     = queue_count_i + outstanding_q;
    assign imem_req_o = !rst_load_q && !outstanding_q && !redirect_o &&
                        (in_use < fetch_pkg::QUEUE_DEPTH);

    // npc only moves on response or redirect, so it is also the pc in flight
    assign imem_addr_o = npc_q;

    // ------------------------------------------------------------------------
    // next pc, lowest priority first
    // ------------------------------------------------------------------------
    always_comb begin
        npc_d = npc_q;
        if (rst_load_q) npc_d = boot_addr_i;
        if (rsp_accept_o) npc_d = predict_i ? predict_addr_i : npc_q + 32'd4;
        if (mispredict_i) npc_d = mispredict_target_i;
        if (eret_i) npc_d = epc_i;
        if (ex_valid_i) npc_d = trap_vector_i;
        // restart after the instruction in commit
        if (commit_flush_i) npc_d = commit_pc_i + 32'd4;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q         <= '0;
            rst_load_q    <= 1'b1;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
        end else begin
            npc_q      <= npc_d;
            rst_load_q <= 1'b0;
            if (imem_req_o) outstanding_q <= 1'b1;
            else if (rsp_i) outstanding_q <= 1'b0;
            // drop the one response still owed to the old path
            if (rsp_i) discard_q <= 1'b0;
            else if (redirect_o && outstanding_q) discard_q <= 1'b1;
        end
    end

endmodule

// File: hdl/frontend.sv
// --------------------------------------------------------------------------
// instruction fetch front end
// fetches one word per request, predicts the next pc and queues entries
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module frontend (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [fetch_pkg::VLEN-1:0] boot_addr_i,
    // memory port
    output logic                       imem_req_o,
    output logic [fetch_pkg::VLEN-1:0] imem_addr_o,
    input  logic                       imem_valid_i,
    input  logic [fetch_pkg::ILEN-1:0] imem_rdata_i,
    input  logic                       imem_err_i,
    // resolved branches from the back end
    input  logic                       resolve_valid_i,
    input  logic [fetch_pkg::VLEN-1:0] resolve_pc_i,
    input  logic                       resolve_branch_i,
    input  logic                       resolve_taken_i,
    input  logic                       resolve_mispredict_i,
    input  logic [fetch_pkg::VLEN-1:0] resolve_target_i,
    // redirects
    input  logic                       commit_flush_i,
    input  logic [fetch_pkg::VLEN-1:0] commit_pc_i,
    input  logic                       ex_valid_i,
    input  logic [fetch_pkg::VLEN-1:0] trap_vector_i,
    input  logic                       eret_i,
    input  logic [fetch_pkg::VLEN-1:0] epc_i,
    input  logic                       bp_flush_i,
    // fetch entries to the back end
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i,
    output logic [fetch_pkg::VLEN-1:0] fetch_pc_o,
    output logic [fetch_pkg::ILEN-1:0] fetch_instr_o,
    output fetch_pkg::cf_e             fetch_cf_o,
    output logic                       fetch_taken_o,
    output logic [fetch_pkg::VLEN-1:0] fetch_target_o,
    output logic                       fetch_ex_o
);
    logic is_branch, is_jal, is_jalr, is_call, is_return;
    logic [fetch_pkg::VLEN-1:0]        imm;
    logic                              bht_valid, bht_taken;
    logic                              ras_valid, ras_push, ras_pop;
    logic [fetch_pkg::VLEN-1:0]        ras_addr;
    logic                              rsp_accept, redirect;
    logic [fetch_pkg::QUEUE_CNT_W-1:0] queue_count;
    logic [fetch_pkg::VLEN-1:0]        seq_pc;
    fetch_pkg::cf_e                    cf;
    logic                              taken;
    logic [fetch_pkg::VLEN-1:0]        target;

    instr_scan i_instr_scan (
        .instr_i     (imem_rdata_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_call_o   (is_call),
        .is_return_o (is_return),
        .imm_o       (imm)
    );

    // ------------------------------------------------------------------------
    // prediction of the returned word, its pc is the address in flight
    // ------------------------------------------------------------------------
    assign seq_pc = imem_addr_o + 32'd4;

    always_comb begin
        cf     = fetch_pkg::CF_NONE;
        taken  = 1'b0;
        target = seq_pc;
        // faulting fetch carries no prediction
        if (!imem_err_i) begin
            if (is_jal) begin
                cf    = fetch_pkg::CF_JUMP;
                taken = 1'b1;
            end else if (is_branch) begin
                cf = fetch_pkg::CF_BRANCH;
                // dynamic when trained, else backward taken
                taken = bht_valid ? bht_taken : imm[fetch_pkg::VLEN-1];
            end else if (is_return) begin
                cf    = fetch_pkg::CF_RETURN;
                taken = ras_valid;
            end else if (is_jalr) begin
                // no btb, falls through
                cf = fetch_pkg::CF_JUMP_REG;
            end
            if (taken) target = is_return ? ras_addr : imem_addr_o + imm;
        end
    end

    // stack only changes for words that enter the queue
    assign ras_push = rsp_accept && !imem_err_i && is_call;
    assign ras_pop  = rsp_accept && !imem_err_i && is_return;

    bht i_bht (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (bp_flush_i),
        .pc_i           (imem_addr_o),
        .valid_o        (bht_valid),
        .taken_o        (bht_taken),
        .update_i       (resolve_valid_i && resolve_branch_i),
        .update_pc_i    (resolve_pc_i),
        .update_taken_i (resolve_taken_i)
    );

    ras i_ras (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (bp_flush_i),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (seq_pc),
        .top_valid_o (ras_valid),
        .top_addr_o  (ras_addr)
    );

    pc_gen i_pc_gen (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .boot_addr_i         (boot_addr_i),
        .mispredict_i        (resolve_valid_i && resolve_mispredict_i),
        .mispredict_target_i (resolve_target_i),
        .commit_flush_i      (commit_flush_i),
        .commit_pc_i         (commit_pc_i),
        .ex_valid_i          (ex_valid_i),
        .trap_vector_i       (trap_vector_i),
        .eret_i              (eret_i),
        .epc_i               (epc_i),
        .rsp_i               (imem_valid_i),
        .predict_i           (taken),
        .predict_addr_i      (target),
        .queue_count_i       (queue_count),
        .imem_req_o          (imem_req_o),
        .imem_addr_o         (imem_addr_o),
        .rsp_accept_o        (rsp_accept),
        .redirect_o          (redirect)
    );

    fetch_queue i_fetch_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (redirect),
        .wr_i           (rsp_accept),
        .wr_pc_i        (imem_addr_o),
        .wr_instr_i     (imem_rdata_i),
        .wr_cf_i        (cf),
        .wr_taken_i     (taken),
        .wr_target_i    (target),
        .wr_ex_i        (imem_err_i),
        .count_o        (queue_count),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_ready_i  (fetch_ready_i),
        .fetch_pc_o     (fetch_pc_o),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_cf_o     (fetch_cf_o),
        .fetch_taken_o  (fetch_taken_o),
        .fetch_target_o (fetch_target_o),
        .fetch_ex_o     (fetch_ex_o)
    );

endmodule

// File: verif/tb_program.svh
// --------------------------------------------------------------------------
// program image and test table for the front end testbench
// --------------------------------------------------------------------------
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// image spans 0x100 to 0x17c and anything else answers with an error
localparam logic [31:0] IMG_BASE = 32'h0000_0100;
localparam logic [31:0] IMG_END  = 32'h0000_0180;
localparam logic [31:0] BOOT     = 32'h0000_0100;

function automatic logic [31:0] image_word(input logic [31:0] addr);
    case (addr)
        32'h108: return 32'h0080_006f;  // jal x0, +8
        32'h110: return 32'h0000_0463;  // beq x0, x0, +8
        32'h118: return 32'hfe00_0ce3;  // beq x0, x0, -8
        32'h140: return 32'h0100_00ef;  // jal ra, +16
        32'h150: return 32'h0100_00ef;  // jal ra, +16
        32'h154: return 32'h0000_8067;  // jalr x0, 0(ra)
        32'h160: return 32'h0000_8067;  // jalr x0, 0(ra)
        // addi x0, x0, addr[11:0] so every filler word is distinct
        default: return {addr[11:0], 20'h0_0013};
    endcase
endfunction

// setup kinds are 0 boot, 1 commit flush, 2 exception with eret, 3 mispredict, 4 eret
// cf codes 0 none, 1 branch, 2 jump and 4 return follow cf_e
// last row flushes the predictors so the branch trained earlier is forgotten
localparam int N_ROWS = 6;
localparam string       ROW_NAME  [N_ROWS] = '{"boot", "static", "call_ret", "bht_train",
                                               "backpressure", "bp_flush"};
localparam int          ROW_KIND  [N_ROWS] = '{0, 1, 2, 3, 4, 1};
localparam logic [31:0] ROW_ADDR  [N_ROWS] = '{32'h0, 32'h104, 32'h140, 32'h110, 32'h140,
                                               32'h10c};
localparam bit          ROW_TRAIN [N_ROWS] = '{0, 0, 0, 1, 0, 0};
localparam bit          ROW_BPF   [N_ROWS] = '{0, 1, 1, 0, 0, 1};
localparam bit          ROW_BP    [N_ROWS] = '{0, 0, 0, 0, 1, 0};
localparam int          ROW_N     [N_ROWS] = '{3, 5, 6, 3, 6, 3};
localparam logic [15:0] ROW_PC [N_ROWS][6] = '{
    '{16'h100, 16'h104, 16'h108, 16'h0, 16'h0, 16'h0},
    '{16'h108, 16'h110, 16'h114, 16'h118, 16'h110, 16'h0},
    '{16'h140, 16'h150, 16'h160, 16'h154, 16'h144, 16'h148},
    '{16'h110, 16'h118, 16'h110, 16'h0, 16'h0, 16'h0},
    '{16'h140, 16'h150, 16'h160, 16'h154, 16'h144, 16'h148},
    '{16'h110, 16'h114, 16'h118, 16'h0, 16'h0, 16'h0}};
localparam int ROW_CF [N_ROWS][6] = '{
    '{0, 0, 2, 0, 0, 0}, '{2, 1, 0, 1, 1, 0}, '{2, 2, 4, 4, 0, 0},
    '{1, 1, 1, 0, 0, 0}, '{2, 2, 4, 4, 0, 0}, '{1, 0, 1, 0, 0, 0}};
localparam bit ROW_TAKEN [N_ROWS][6] = '{
    '{0, 0, 1, 0, 0, 0}, '{1, 0, 0, 1, 0, 0}, '{1, 1, 1, 1, 0, 0},
    '{1, 1, 1, 0, 0, 0}, '{1, 1, 1, 1, 0, 0}, '{0, 0, 1, 0, 0, 0}};

`endif

// File: verif/tb_frontend.sv
// --------------------------------------------------------------------------
// front end testbench
// memory model, table of redirect scenarios and checks of every entry
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_frontend;
    logic        clk_i, rst_ni;
    logic [31:0] boot_addr_i;
    logic        imem_req_o, imem_valid_i, imem_err_i;
    logic [31:0] imem_addr_o, imem_rdata_i;
    logic        resolve_valid_i, resolve_branch_i, resolve_taken_i, resolve_mispredict_i;
    logic [31:0] resolve_pc_i, resolve_target_i;
    logic        commit_flush_i, ex_valid_i, eret_i, bp_flush_i;
    logic [31:0] commit_pc_i, trap_vector_i, epc_i;
    logic        fetch_valid_o, fetch_ready_i, fetch_taken_o, fetch_ex_o;
    logic [31:0] fetch_pc_o, fetch_instr_o, fetch_target_o;
    fetch_pkg::cf_e fetch_cf_o;

    int errors, row_errs, tests_ok, tests_bad;

    `include "tb_program.svh"

    frontend i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // memory model, one request at a time with 1 to 3 cycles latency
    // ------------------------------------------------------------------------
    always begin
        logic [31:0] addr;
        int unsigned lat;
        @(negedge clk_i);
        if (rst_ni && imem_req_o) begin
            addr = imem_addr_o;
            lat  = 1 + $urandom % 3;
            repeat (lat) @(posedge clk_i);
            imem_valid_i <= 1'b1;
            imem_rdata_i <= image_word(addr);
            imem_err_i   <= (addr < IMG_BASE) || (addr >= IMG_END);
            @(posedge clk_i);
            imem_valid_i <= 1'b0;
        end
    end

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
        row_errs++;
    endtask

    // pc plus the jal or branch offset, decoded from the raw bits
    function automatic logic [31:0] offset_target(input logic [31:0] pc, input logic [31:0] w);
        logic [31:0] off;
        if (w[6:0] == 7'h6f) off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        else off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        return pc + off;
    endfunction

    // training strobes, then the redirect cycle of the row
    task automatic apply_setup(input int r);
        if (ROW_TRAIN[r]) begin
            repeat (2) begin
                @(posedge clk_i);
                resolve_valid_i  <= 1'b1;
                resolve_pc_i     <= ROW_ADDR[r];
                resolve_branch_i <= 1'b1;
                resolve_taken_i  <= 1'b1;
            end
        end
        @(posedge clk_i);
        resolve_valid_i  <= 1'b0;
        resolve_branch_i <= 1'b0;
        bp_flush_i       <= ROW_BPF[r];
        case (ROW_KIND[r])
            1: begin
                commit_flush_i <= 1'b1;
                commit_pc_i    <= ROW_ADDR[r];
            end
            2: begin
                // eret loses against the exception
                ex_valid_i    <= 1'b1;
                trap_vector_i <= ROW_ADDR[r];
                eret_i        <= 1'b1;
                epc_i         <= BOOT;
            end
            3: begin
                resolve_valid_i      <= 1'b1;
                resolve_mispredict_i <= 1'b1;
                resolve_target_i     <= ROW_ADDR[r];
            end
            default: begin
                eret_i <= 1'b1;
                epc_i  <= ROW_ADDR[r];
            end
        endcase
        @(posedge clk_i);
        commit_flush_i       <= 1'b0;
        ex_valid_i           <= 1'b0;
        eret_i               <= 1'b0;
        resolve_valid_i      <= 1'b0;
        resolve_mispredict_i <= 1'b0;
        bp_flush_i           <= 1'b0;
        @(negedge clk_i);
        if (fetch_valid_o) report_error("queue not empty after redirect");
    endtask

    task automatic check_entry(input int r, input int e);
        logic [31:0] pc;
        logic [31:0] tgt;
        pc = {16'h0, ROW_PC[r][e]};
        if (fetch_pc_o !== pc)
            report_error($sformatf("pc %h, expected %h", fetch_pc_o, pc));
        if (fetch_instr_o !== image_word(pc))
            report_error($sformatf("instr %h at pc %h", fetch_instr_o, pc));
        if (int'(fetch_cf_o) != ROW_CF[r][e])
            report_error($sformatf("cf %0d at pc %h, expected %0d",
                                   fetch_cf_o, pc, ROW_CF[r][e]));
        if (fetch_taken_o !== ROW_TAKEN[r][e])
            report_error($sformatf("taken %b at pc %h", fetch_taken_o, pc));
        if (fetch_ex_o !== 1'b0)
            report_error($sformatf("unexpected fetch error at pc %h", pc));
        if (ROW_TAKEN[r][e] && (ROW_CF[r][e] != 4 || e + 1 < ROW_N[r])) begin
            tgt = (ROW_CF[r][e] == 4) ? {16'h0, ROW_PC[r][e+1]} :
                                        offset_target(pc, image_word(pc));
            if (fetch_target_o !== tgt)
                report_error($sformatf("target %h at pc %h, expected %h",
                                       fetch_target_o, pc, tgt));
        end
    endtask

    task automatic collect_entries(input int r);
        int cycles;
        bit got;
        @(posedge clk_i);
        fetch_ready_i <= ROW_BP[r] ? 1'($urandom % 2) : 1'b1;
        for (int e = 0; e < ROW_N[r]; e++) begin
            cycles = 0;
            got    = 1'b0;
            while (!got) begin
                @(negedge clk_i);
                if (fetch_valid_o && fetch_ready_i) begin
                    got = 1'b1;
                end else begin
                    cycles++;
                    if (cycles > 200) abort_run("a fetch entry");
                    @(posedge clk_i);
                    if (ROW_BP[r]) fetch_ready_i <= 1'($urandom % 2);
                end
            end
            check_entry(r, e);
            @(posedge clk_i);
            // hold the queue between rows
            if (e == ROW_N[r] - 1) fetch_ready_i <= 1'b0;
            else fetch_ready_i <= ROW_BP[r] ? 1'($urandom % 2) : 1'b1;
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(32'hd6d7_c013));
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        rst_ni = 1'b0;
        boot_addr_i = BOOT;
        imem_valid_i = 1'b0;
        imem_rdata_i = '0;
        imem_err_i = 1'b0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_branch_i = 1'b0;
        resolve_taken_i = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i = '0;
        commit_flush_i = 1'b0;
        commit_pc_i = '0;
        ex_valid_i = 1'b0;
        trap_vector_i = '0;
        eret_i = 1'b0;
        epc_i = '0;
        bp_flush_i = 1'b0;
        fetch_ready_i = 1'b0;

        // reset and the first cycle after it stay quiet
        for (int i = 0; i < 6; i++) begin
            @(negedge clk_i);
            if (imem_req_o || fetch_valid_o) report_error("activity during reset");
            if (i == 4) @(posedge clk_i) rst_ni <= 1'b1;
        end
        cycles = 0;
        @(negedge clk_i);
        while (!imem_req_o) begin
            cycles++;
            if (cycles > 20) abort_run("the first request");
            @(negedge clk_i);
        end
        if (cycles != 0 || imem_addr_o !== BOOT)
            report_error($sformatf("first request at %h after %0d extra cycles",
                                   imem_addr_o, cycles));

        for (int r = 0; r < N_ROWS; r++) begin
            row_errs = 0;
            if (ROW_KIND[r] != 0) apply_setup(r);
            collect_entries(r);
            if (row_errs == 0) tests_ok++;
            else tests_bad++;
            $display("test %s: %s", ROW_NAME[r], (row_errs == 0) ? "ok" : "failed");
        end

        $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
hdl/fetch_pkg.sv
hdl/rv_instr_pkg.sv
hdl/instr_scan.sv
hdl/bht.sv
hdl/ras.sv
hdl/fetch_queue.sv
hdl/pc_gen.sv
hdl/frontend.sv
verif/tb_frontend.sv

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f compile.f --top-module tb_frontend -o tb_frontend_sim \
    && ./obj_dir/tb_frontend_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation did not run"; exit 1; }
cat sim.log
grep -q "^PASS: all tests$" sim.log && exit 0 || exit 1
